//--- rtl/host_rd_credits.sv
`timescale 1ns/1ps
`default_nettype none

module host_rd_credits (
  input  logic                                                aclk,
  input  logic                                                rst_n,
  // requests from the destinations.
  input  logic [rdc_pkg::n_dests-1:0]                         s_req_valid,
  output logic [rdc_pkg::n_dests-1:0]                         s_req_ready,
  input  logic [rdc_pkg::n_dests-1:0][rdc_pkg::addr_bits-1:0] s_req_addr,
  input  logic [rdc_pkg::n_dests-1:0][rdc_pkg::len_bits-1:0]  s_req_len,
  // merged requests to the host.
  output logic                                                m_req_valid,
  input  logic                                                m_req_ready,
  output logic [rdc_pkg::addr_bits-1:0]                       m_req_addr,
  output logic [rdc_pkg::len_bits-1:0]                        m_req_len,
  // read data from the host in request order.
  input  logic                                                s_axis_tvalid,
  output logic                                                s_axis_tready,
  input  logic [rdc_pkg::data_bits-1:0]                       s_axis_tdata,
  input  logic [rdc_pkg::keep_bits-1:0]                       s_axis_tkeep,
  input  logic                                                s_axis_tlast,
  // read data to the destinations.
  output logic [rdc_pkg::n_dests-1:0]                         m_axis_tvalid,
  input  logic [rdc_pkg::n_dests-1:0]                         m_axis_tready,
  output logic [rdc_pkg::n_dests-1:0][rdc_pkg::data_bits-1:0] m_axis_tdata,
  output logic [rdc_pkg::n_dests-1:0][rdc_pkg::keep_bits-1:0] m_axis_tkeep,
  output logic [rdc_pkg::n_dests-1:0]                         m_axis_tlast
);

  import rdc_pkg::*;

  rdc_meta_if #(.payload_t(req_t))  req_in   [n_dests] ();
  rdc_meta_if #(.payload_t(req_t))  req_q    [n_dests] ();
  rdc_meta_if #(.payload_t(req_t))  req_cred [n_dests] ();
  rdc_meta_if #(.payload_t(ord_t))  ord_in ();
  rdc_meta_if #(.payload_t(ord_t))  ord_q ();
  rdc_meta_if #(.payload_t(beat_t)) beat_in  [n_dests] ();
  rdc_meta_if #(.payload_t(beat_t)) beat_out [n_dests] ();

  logic [n_dests-1:0] xfer;  // beat handed to a destination.

  // **************************************************
  // request side for each destination.
  // **************************************************
  for (genvar g = 0; g < n_dests; g++) begin : g_req
    assign req_in[g].valid = s_req_valid[g];
    assign req_in[g].data  = req_t'{addr: s_req_addr[g], len: s_req_len[g]};
    assign s_req_ready[g]  = req_in[g].ready;

    rdc_fifo #(.payload_t(req_t), .depth(req_q_depth)) req_fifo_i (
      .aclk  (aclk),
      .rst_n (rst_n),
      .s     (req_in[g]),
      .m     (req_q[g])
    );

    rdc_credit_gate gate_i (
      .aclk  (aclk),
      .rst_n (rst_n),
      .s     (req_q[g]),
      .m     (req_cred[g]),
      .xfer  (xfer[g])
    );
  end

  // merge and remember order.
  rdc_req_arb arb_i (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .s           (req_cred),
    .m_req_valid (m_req_valid),
    .m_req_ready (m_req_ready),
    .m_req_addr  (m_req_addr),
    .m_req_len   (m_req_len),
    .ord         (ord_in)
  );

  rdc_fifo #(.payload_t(ord_t), .depth(ord_q_depth)) ord_fifo_i (
    .aclk  (aclk),
    .rst_n (rst_n),
    .s     (ord_in),
    .m     (ord_q)
  );

  // **************************************************
  // data side.
  // **************************************************
  rdc_data_router router_i (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .ord           (ord_q),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tkeep  (s_axis_tkeep),
    .s_axis_tlast  (s_axis_tlast),
    .m             (beat_in)
  );

  for (genvar g = 0; g < n_dests; g++) begin : g_data
    // sized to a full credit pool, so it never overflows.
    rdc_fifo #(.payload_t(beat_t), .depth(max_beats)) data_fifo_i (
      .aclk  (aclk),
      .rst_n (rst_n),
      .s     (beat_in[g]),
      .m     (beat_out[g])
    );

    assign m_axis_tvalid[g]   = beat_out[g].valid;
    assign beat_out[g].ready  = m_axis_tready[g];
    assign m_axis_tdata[g]    = beat_out[g].data.data;
    assign m_axis_tkeep[g]    = beat_out[g].data.keep;
    assign m_axis_tlast[g]    = beat_out[g].data.last;

    assign xfer[g] = m_axis_tvalid[g] & m_axis_tready[g];  // refund one credit.
  end

endmodule

`default_nettype wire

//--- rtl/rdc_credit_gate.sv
`timescale 1ns/1ps
`default_nettype none

// holds a request back until its whole reply fits the data fifo.
module rdc_credit_gate (
  input  logic    aclk,
  input  logic    rst_n,
  rdc_meta_if.snk s,     // from request queue.
  rdc_meta_if.src m,     // to arbiter.
  input  logic    xfer   // one beat left the data fifo.
);

  import rdc_pkg::*;

  logic [len_bits-1:0] credits;  // free beats in the data fifo.
  logic [len_bits-1:0] charge;
  logic                fits;
  logic                issue;

  // **************************************************
  // gating.
  // **************************************************
  assign fits = (s.data.len <= credits);

  assign m.valid = s.valid & fits;
  assign m.data  = s.data;         // request passes unchanged.
  assign s.ready = m.ready & fits;

  assign issue  = m.valid & m.ready;
  assign charge = issue ? s.data.len : '0;  // whole reply reserved up front.

  // **************************************************
  // credit counter.
  // **************************************************
  // charge and refund may land in the same cycle.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= len_bits'(max_beats);  // fifo empty.
    end else begin
      credits <= credits - charge + len_bits'(xfer);
    end
  end

  // refunds never outrun charges.
  a_credit_max : assert property (@(posedge aclk) disable iff (!rst_n)
    credits <= len_bits'(max_beats));

  // a zero-length request would leave a record the router never pops.
  a_len_nonzero : assert property (@(posedge aclk) disable iff (!rst_n)
    s.valid |-> (s.data.len != '0));

endmodule

`default_nettype wire

//--- rtl/rdc_data_router.sv
`timescale 1ns/1ps
`default_nettype none

// replies return in issue order, so the head record names the owner of each beat.
module rdc_data_router (
  input  logic                          aclk,
  input  logic                          rst_n,
  rdc_meta_if.snk                       ord,  // head of order fifo.
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  input  logic [rdc_pkg::data_bits-1:0] s_axis_tdata,
  input  logic [rdc_pkg::keep_bits-1:0] s_axis_tkeep,
  input  logic                          s_axis_tlast,
  rdc_meta_if.src                       m [rdc_pkg::n_dests]  // to data fifos.
);

  import rdc_pkg::*;

  logic [len_bits-1:0] beat_cnt;   // beats already routed for the head record.
  logic [n_dests-1:0]  dst_ready;
  logic                sel_ready;
  logic                last_beat;
  logic                beat_fire;
  beat_t               beat;

  // **************************************************
  // steering.
  // **************************************************
  assign beat = beat_t'{data: s_axis_tdata, keep: s_axis_tkeep, last: s_axis_tlast};

  for (genvar g = 0; g < n_dests; g++) begin : g_out
    assign dst_ready[g] = m[g].ready;
    assign m[g].valid   = s_axis_tvalid & ord.valid & (ord.data.dest == dest_bits'(g));
    assign m[g].data    = beat;  // every fifo sees the beat but only one gets valid.
  end

  assign sel_ready     = dst_ready[ord.data.dest];
  assign s_axis_tready = ord.valid & sel_ready;  // beats wait for a record.
  assign beat_fire     = s_axis_tvalid & s_axis_tready;

  assign last_beat = (len_bits'(beat_cnt + 1'b1) == ord.data.len);
  assign ord.ready = beat_fire & last_beat;  // record retires on its final beat.

  // **************************************************
  // beat counter.
  // **************************************************
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (beat_fire) begin
      beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

  // host framing must agree with the recorded length.
  a_tlast_match : assert property (@(posedge aclk) disable iff (!rst_n)
    beat_fire |-> (s_axis_tlast == last_beat));

endmodule

`default_nettype wire

//--- rtl/rdc_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rdc_fifo #(
  parameter type payload_t = logic,
  parameter int  depth     = 4
) (
  input  logic    aclk,
  input  logic    rst_n,
  rdc_meta_if.snk s,
  rdc_meta_if.src m
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;

  payload_t            mem [depth];  // ring storage.
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [ptr_bits:0]   count;        // number of entries held.
  logic                push;
  logic                pop;

  // **************************************************
  // handshakes.
  // **************************************************
  assign s.ready = (count != (ptr_bits + 1)'(depth));  // low when full.
  assign m.valid = (count != '0);
  assign m.data  = mem[rd_ptr];  // registered head entry.

  assign push = s.valid & s.ready;
  assign pop  = m.valid & m.ready;

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= s.data;
  end

  // **************************************************
  // pointers and count.
  // **************************************************
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or both.
      endcase
    end
  end

  // occupancy bound.
  a_count_bound : assert property (@(posedge aclk) disable iff (!rst_n)
    count <= (ptr_bits + 1)'(depth));

endmodule

`default_nettype wire

//--- rtl/rdc_meta_if.sv
`timescale 1ns/1ps
`default_nettype none

// generic valid/ready channel.
interface rdc_meta_if #(
  parameter type payload_t = logic
);

  logic     valid;  // held until accepted.
  logic     ready;
  payload_t data;   // stable while valid.

  modport src (
    output valid,
    output data,
    input  ready
  );

  modport snk (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

//--- rtl/rdc_pkg.sv
`default_nettype none

package rdc_pkg;

  // **************************************************
  // sizing.
  // **************************************************
  localparam int n_dests     = 2;   // local destinations.
  localparam int addr_bits   = 32;  // host address.
  localparam int data_bits   = 64;  // one data beat.
  localparam int keep_bits   = data_bits / 8;
  localparam int max_beats   = 16;  // longest request and the data fifo depth and credit pool.
  localparam int len_bits    = 5;   // holds 1..16.
  localparam int dest_bits   = 1;   // destination index.
  localparam int req_q_depth = 4;   // per-destination request queue.
  localparam int ord_q_depth = 8;   // outstanding requests on the host side.

  // **************************************************
  // payloads.
  // **************************************************
  typedef struct packed {
    logic [addr_bits-1:0] addr;
    logic [len_bits-1:0]  len;    // beat count that is never zero.
  } req_t;

  // one record per issued request in host order.
  typedef struct packed {
    logic [dest_bits-1:0] dest;
    logic [len_bits-1:0]  len;
  } ord_t;

  typedef struct packed {
    logic [data_bits-1:0] data;
    logic [keep_bits-1:0] keep;
    logic                 last;
  } beat_t;

endpackage

`default_nettype wire

//--- rtl/rdc_req_arb.sv
`timescale 1ns/1ps
`default_nettype none

module rdc_req_arb (
  input  logic                          aclk,
  input  logic                          rst_n,
  rdc_meta_if.snk                       s [rdc_pkg::n_dests],  // gated requests.
  output logic                          m_req_valid,
  input  logic                          m_req_ready,
  output logic [rdc_pkg::addr_bits-1:0] m_req_addr,
  output logic [rdc_pkg::len_bits-1:0]  m_req_len,
  rdc_meta_if.src                       ord    // issue order to the order fifo.
);

  import rdc_pkg::*;

  logic [n_dests-1:0]   req;
  req_t                 req_data [n_dests];
  logic [n_dests-1:0]   grant;
  logic [dest_bits-1:0] win_idx;
  logic [dest_bits-1:0] prio;      // first in line this round.
  logic                 out_free;  // output register can take a request.
  logic                 load;

  for (genvar g = 0; g < n_dests; g++) begin : g_in
    assign req[g]      = s[g].valid;
    assign req_data[g] = s[g].data;
    assign s[g].ready  = grant[g] & out_free & ord.ready;
  end

  // **************************************************
  // round robin pick.
  // **************************************************
  always_comb begin
    int idx;
    logic found;
    grant   = '0;
    win_idx = prio;
    found   = 1'b0;
    for (int k = 0; k < n_dests; k++) begin
      idx = (int'(prio) + k) % n_dests;  // scan from prio upward.
      if (!found && req[idx]) begin
        grant[idx] = 1'b1;
        win_idx    = dest_bits'(idx);
        found      = 1'b1;
      end
    end
  end

  assign out_free = ~m_req_valid | m_req_ready;
  assign load     = (|req) & out_free & ord.ready;  // host slot and order slot both free.

  // order record leaves with the request.
  assign ord.valid = (|req) & out_free;
  assign ord.data  = ord_t'{dest: win_idx, len: req_data[win_idx].len};

  // **************************************************
  // host output register.
  // **************************************************
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_req_valid <= 1'b0;
      prio        <= '0;
    end else begin
      if (load) m_req_valid <= 1'b1;
      else if (m_req_ready) m_req_valid <= 1'b0;
      // winner drops to the back.
      if (load) prio <= (win_idx == dest_bits'(n_dests - 1)) ? '0 : win_idx + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (load) begin
      m_req_addr <= req_data[win_idx].addr;
      m_req_len  <= req_data[win_idx].len;
    end
  end

  a_grant_onehot : assert property (@(posedge aclk) disable iff (!rst_n)
    (|req) |-> $onehot(grant));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_host_rd_credits \
  -Mdir obj_dir -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

//--- sim.f
rtl/rdc_pkg.sv
rtl/rdc_meta_if.sv
rtl/rdc_fifo.sv
rtl/rdc_credit_gate.sv
rtl/rdc_req_arb.sv
rtl/rdc_data_router.sv
rtl/host_rd_credits.sv
tests/tb_host_rd_credits.sv

//--- tests/tb_host_rd_credits.sv
`timescale 1ns/1ps
`default_nettype none

module tb_host_rd_credits;

  import rdc_pkg::*;

  logic                              aclk;
  logic                              rst_n;
  logic [n_dests-1:0]                s_req_valid;
  logic [n_dests-1:0]                s_req_ready;
  logic [n_dests-1:0][addr_bits-1:0] s_req_addr;
  logic [n_dests-1:0][len_bits-1:0]  s_req_len;
  logic                              m_req_valid;
  logic                              m_req_ready;
  logic [addr_bits-1:0]              m_req_addr;
  logic [len_bits-1:0]               m_req_len;
  logic                              s_axis_tvalid = 1'b0;
  logic                              s_axis_tready;
  logic [data_bits-1:0]              s_axis_tdata  = '0;
  logic [keep_bits-1:0]              s_axis_tkeep  = '1;  // all bytes valid.
  logic                              s_axis_tlast  = 1'b0;
  logic [n_dests-1:0]                m_axis_tvalid;
  logic [n_dests-1:0]                m_axis_tready;
  logic [n_dests-1:0][data_bits-1:0] m_axis_tdata;
  logic [n_dests-1:0][keep_bits-1:0] m_axis_tkeep;
  logic [n_dests-1:0]                m_axis_tlast;

  // **************************************************
  // testbench state.
  // **************************************************
  logic                 rand_ready;                   // readies from the lfsr.
  logic                 req_ready_set;
  logic [n_dests-1:0]   axis_ready_set;
  logic                 rnd_req_ready  = 1'b0;
  logic [n_dests-1:0]   rnd_axis_ready = '0;
  logic [31:0]          lfsr_rdy = 32'h2036_9f52;     // host side readies.
  logic [31:0]          lfsr_len = 32'h2036_9f52;     // request lengths.
  int                   errors;
  int                   mon_errors;                   // counted by the beat monitor.
  int                   err_mark;
  int                   n_tests;
  int                   n_bad;
  logic [addr_bits-1:0] hq_addr [$];                  // issued and awaiting a reply.
  logic [len_bits-1:0]  hq_len [$];
  int                   beat_idx;
  int                   host_beats;
  logic [addr_bits-1:0] iss_addr [64];                // log of m_req in issue order.
  logic [len_bits-1:0]  iss_len [64];
  int                   iss_dest [64];
  int                   iss_cnt;
  logic [addr_bits-1:0] exp_addr [n_dests][64];       // expected replies per destination.
  logic [len_bits-1:0]  exp_len [n_dests][64];
  int                   exp_wr [n_dests];
  int                   exp_rd [n_dests];
  int                   beat_pos [n_dests];
  int                   got_beats [n_dests];

  assign m_req_ready   = rand_ready ? rnd_req_ready : req_ready_set;
  assign m_axis_tready = rand_ready ? rnd_axis_ready : axis_ready_set;

  host_rd_credits dut_i (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // fibonacci with taps 32 22 2 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic compare(string name, logic [63:0] got, logic [63:0] exp,
                         inout int err_count);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
      err_count++;
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("timeout waiting for %s at %0t", what, $time);
    $display("tests failed");
    $finish;
  endtask

  task automatic report_test(string name);
    n_tests++;
    if (errors + mon_errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      n_bad++;
      $display("test %s: %0d errors", name, errors + mon_errors - err_mark);
    end
    err_mark = errors + mon_errors;
  endtask

  // sel below n_dests picks delivered beats, n_dests issues, above that host beats.
  function automatic int count_of(int sel);
    if (sel < n_dests) return got_beats[sel];
    if (sel == n_dests) return iss_cnt;
    return host_beats;
  endfunction

  task automatic wait_for(string what, int sel, int target, int limit);
    int t;
    t = 0;
    while (count_of(sel) < target) begin
      if (t == limit) abort_on_timeout(what);
      t++;
      @(posedge aclk);
      #1;
    end
  endtask

  // queue one request and note the reply it must bring.
  task automatic send_req(int d, logic [addr_bits-1:0] addr, logic [len_bits-1:0] len);
    int t;
    exp_addr[d][exp_wr[d] % 64] = addr;
    exp_len[d][exp_wr[d] % 64]  = len;
    exp_wr[d]++;
    s_req_valid[d] = 1'b1;
    s_req_addr[d]  = addr;
    s_req_len[d]   = len;
    t = 0;
    while (!s_req_ready[d]) begin
      if (t == 2000) abort_on_timeout("s_req_ready");
      t++;
      @(posedge aclk);
      #1;
    end
    @(posedge aclk);  // transfer edge.
    #1;
    s_req_valid[d] = 1'b0;
  endtask

  // **************************************************
  // host model that replies in request order.
  // **************************************************
  always @(posedge aclk) begin
    logic [2:0] rdy_bits;
    if (s_axis_tvalid && s_axis_tready) begin
      host_beats++;
      if (beat_idx + 1 == int'(hq_len[0])) begin
        hq_addr.delete(0);
        hq_len.delete(0);
        beat_idx = 0;
      end else begin
        beat_idx++;
      end
    end
    if (m_req_valid && m_req_ready) begin
      hq_addr.push_back(m_req_addr);
      hq_len.push_back(m_req_len);
      iss_addr[iss_cnt] = m_req_addr;
      iss_len[iss_cnt]  = m_req_len;
      iss_dest[iss_cnt] = int'(m_req_addr[31:28]) - 1;  // address top nibble names the dest.
      iss_cnt++;
    end
    #1;
    s_axis_tvalid = (hq_addr.size() != 0);
    if (hq_addr.size() != 0) begin
      s_axis_tdata = 64'(hq_addr[0]) + 64'(beat_idx);
      s_axis_tlast = (beat_idx + 1 == int'(hq_len[0]));
    end
    repeat (3) begin
      lfsr_rdy = lfsr_step(lfsr_rdy);
      rdy_bits = {rdy_bits[1:0], lfsr_rdy[0]};
    end
    rnd_req_ready  = rdy_bits[2];
    rnd_axis_ready = rdy_bits[1:0];
  end

  // beat monitor for each destination.
  always @(posedge aclk) begin
    int   k;
    logic last_exp;
    for (int d = 0; d < n_dests; d++) begin
      if (m_axis_tvalid[d] && m_axis_tready[d]) begin
        if (exp_rd[d] == exp_wr[d]) begin
          $display("unexpected beat on destination %0d at %0t", d, $time);
          mon_errors++;
        end else begin
          k        = exp_rd[d] % 64;
          last_exp = (beat_pos[d] + 1 == int'(exp_len[d][k]));
          compare("m_axis_tdata", m_axis_tdata[d],
                  64'(exp_addr[d][k]) + 64'(beat_pos[d]), mon_errors);
          compare("m_axis_tkeep", 64'(m_axis_tkeep[d]), 64'(8'hff), mon_errors);
          compare("m_axis_tlast", 64'(m_axis_tlast[d]), 64'(last_exp), mon_errors);
          got_beats[d]++;
          if (last_exp) begin
            beat_pos[d] = 0;
            exp_rd[d]++;
          end else begin
            beat_pos[d]++;
          end
        end
      end
    end
  end

  // **************************************************
  // directed tests.
  // **************************************************
  task automatic reset_and_single();
    compare("m_req_valid", 64'(m_req_valid), 64'(0), errors);
    compare("m_axis_tvalid", 64'(m_axis_tvalid), 64'(0), errors);
    compare("s_axis_tready", 64'(s_axis_tready), 64'(0), errors);
    compare("s_req_ready", 64'(s_req_ready), 64'(2'b11), errors);
    send_req(0, 32'h1000_0040, 5'd4);
    wait_for("m_req issue", n_dests, 1, 50);
    compare("m_req_addr", 64'(iss_addr[0]), 64'(32'h1000_0040), errors);
    compare("m_req_len", 64'(iss_len[0]), 64'(4), errors);
    wait_for("destination 0 beats", 0, 4, 200);
    report_test("reset_and_single");
  endtask

  task automatic two_destinations();
    int b0;
    int b1;
    b0 = got_beats[0];
    b1 = got_beats[1];
    fork
      send_req(0, 32'h1000_0100, 5'd3);
      send_req(1, 32'h2000_0100, 5'd5);
    join
    wait_for("destination 0 beats", 0, b0 + 3, 200);
    wait_for("destination 1 beats", 1, b1 + 5, 200);
    report_test("two_destinations");
  endtask

  task automatic credit_limit();
    int hb;
    int ic;
    int b0;
    axis_ready_set[0] = 1'b0;  // dest 0 stops draining.
    hb = host_beats;
    b0 = got_beats[0];
    send_req(0, 32'h1000_0200, 5'd16);
    wait_for("host beats", n_dests + 1, hb + 16, 300);
    compare("m_axis_tvalid", 64'(m_axis_tvalid[0]), 64'(1), errors);
    ic = iss_cnt;
    send_req(0, 32'h1000_0300, 5'd1);
    repeat (40) @(posedge aclk);
    #1;
    compare("m_req issue count", 64'(iss_cnt), 64'(ic), errors);  // no credit left.
    axis_ready_set[0] = 1'b1;
    wait_for("destination 0 beats", 0, b0 + 17, 300);
    compare("m_req issue count", 64'(iss_cnt), 64'(ic + 1), errors);
    report_test("credit_limit");
  endtask

  task automatic round_robin();
    int base;
    int b0;
    int b1;
    base          = iss_cnt;
    b0            = got_beats[0];
    b1            = got_beats[1];
    req_ready_set = 1'b0;  // build up a backlog on both sides.
    fork
      begin
        for (int i = 0; i < 3; i++) send_req(0, 32'h1000_0400 + i * 32'h100, 5'd2);
      end
      begin
        for (int i = 0; i < 3; i++) send_req(1, 32'h2000_0400 + i * 32'h100, 5'd2);
      end
    join
    req_ready_set = 1'b1;
    wait_for("m_req issue", n_dests, base + 6, 100);
    for (int i = 1; i < 6; i++) begin
      compare("issued destination", 64'(iss_dest[base + i]),
              64'(1 - iss_dest[base + i - 1]), errors);
    end
    wait_for("destination 0 beats", 0, b0 + 6, 200);
    wait_for("destination 1 beats", 1, b1 + 6, 200);
    report_test("round_robin");
  endtask

  task automatic random_ready();
    logic [len_bits-1:0] lens [n_dests][10];
    logic [3:0]          r;
    int                  b [n_dests];
    int                  total [n_dests];
    for (int d = 0; d < n_dests; d++) begin
      b[d]     = got_beats[d];
      total[d] = 0;
      for (int i = 0; i < 10; i++) begin
        r = '0;
        repeat (4) begin
          lfsr_len = lfsr_step(lfsr_len);
          r        = {r[2:0], lfsr_len[0]};
        end
        lens[d][i] = {1'b0, r} + 5'd1;  // 1..16 beats.
        total[d] += int'(lens[d][i]);
      end
    end
    rand_ready = 1'b1;
    fork
      begin
        for (int i = 0; i < 10; i++) send_req(0, 32'h1000_1000 + i * 32'h100, lens[0][i]);
      end
      begin
        for (int i = 0; i < 10; i++) send_req(1, 32'h2000_1000 + i * 32'h100, lens[1][i]);
      end
    join
    wait_for("destination 0 beats", 0, b[0] + total[0], 4000);
    wait_for("destination 1 beats", 1, b[1] + total[1], 4000);
    rand_ready = 1'b0;
    report_test("random_ready");
  endtask

  initial begin
    rst_n          = 1'b0;
    s_req_valid    = '0;
    s_req_addr     = '0;
    s_req_len      = '0;
    req_ready_set  = 1'b1;
    axis_ready_set = '1;
    rand_ready     = 1'b0;
    repeat (2) @(posedge aclk);
    #1;
    rst_n = 1'b1;
    reset_and_single();
    two_destinations();
    credit_limit();
    round_robin();
    random_ready();
    $display("summary: %0d run, %0d ok, %0d with errors, %0d mismatches", n_tests,
             n_tests - n_bad, n_bad, errors + mon_errors);
    if (n_bad == 0 && errors + mon_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
